/* hdl/fft_types_pkg.sv */
`default_nettype none

package fft_types_pkg;

    // Transform geometry
    localparam int fft_points = 16;
    localparam int radix = 4;
    localparam int counter_bits = 4;

    // Component widths, two bits of growth per stage
    localparam int in_width = 13;
    localparam int s1_width = 15;
    localparam int s2_width = 17;

    // Input format is S1.11
    typedef logic signed [in_width-1:0] in_sample_t;
    typedef logic signed [s1_width-1:0] s1_sample_t;
    typedef logic signed [s2_width-1:0] s2_sample_t;
    typedef logic [counter_bits-1:0] frame_count_t;

    // Quarter of the frame as seen by one SDF stage
    typedef enum logic [1:0] {fill_0, fill_1, fill_2, compute} stage_phase_t;

endpackage

`default_nettype wire

/* hdl/twiddle_pkg.sv */
`default_nettype none

package twiddle_pkg;

    // 1.0 maps to 1024
    localparam int twiddle_frac_bits = 10;
    localparam int twiddle_width = 12;

    typedef logic signed [twiddle_width-1:0] twiddle_t;

    // Entry c holds W16 ** ((c mod 4) * (c div 4))
    // Row r of four entries belongs to butterfly output y_r
    localparam twiddle_t twiddle_re [fft_types_pkg::fft_points] = '{
        12'sd1024, 12'sd1024, 12'sd1024, 12'sd1024,
        12'sd1024, 12'sd946, 12'sd724, 12'sd392,
        12'sd1024, 12'sd724, 12'sd0, -12'sd724,
        12'sd1024, 12'sd392, -12'sd724, -12'sd946
    };

    // Imaginary part is minus the sine
    localparam twiddle_t twiddle_im [fft_types_pkg::fft_points] = '{
        12'sd0, 12'sd0, 12'sd0, 12'sd0,
        12'sd0, -12'sd392, -12'sd724, -12'sd946,
        12'sd0, -12'sd724, -12'sd1024, -12'sd724,
        12'sd0, -12'sd946, -12'sd724, 12'sd392
    };

endpackage

`default_nettype wire

/* hdl/radix4_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface radix4_if #(
    parameter int width = 15
);
    // Butterfly inputs
    logic signed [width-1:0] a0_re, a0_im;
    logic signed [width-1:0] a1_re, a1_im;
    logic signed [width-1:0] a2_re, a2_im;
    logic signed [width-1:0] a3_re, a3_im;

    // Butterfly outputs
    logic signed [width-1:0] y0_re, y0_im;
    logic signed [width-1:0] y1_re, y1_im;
    logic signed [width-1:0] y2_re, y2_im;
    logic signed [width-1:0] y3_re, y3_im;

    modport stage (
        output a0_re, a0_im, a1_re, a1_im, a2_re, a2_im, a3_re, a3_im,
        input  y0_re, y0_im, y1_re, y1_im, y2_re, y2_im, y3_re, y3_im
    );

    modport butterfly (
        input  a0_re, a0_im, a1_re, a1_im, a2_re, a2_im, a3_re, a3_im,
        output y0_re, y0_im, y1_re, y1_im, y2_re, y2_im, y3_re, y3_im
    );

endinterface

`default_nettype wire

/* hdl/radix4_butterfly.sv */
`timescale 1ns/1ns
`default_nettype none

module radix4_butterfly #(
    parameter int width = 15
) (
    radix4_if.butterfly bf
);
    // Partial sums shared by all four outputs
    logic signed [width-1:0] s02_re, s02_im;
    logic signed [width-1:0] d02_re, d02_im;
    logic signed [width-1:0] s13_re, s13_im;
    logic signed [width-1:0] d13_re, d13_im;

    assign s02_re = bf.a0_re + bf.a2_re;
    assign s02_im = bf.a0_im + bf.a2_im;
    assign d02_re = bf.a0_re - bf.a2_re;
    assign d02_im = bf.a0_im - bf.a2_im;
    assign s13_re = bf.a1_re + bf.a3_re;
    assign s13_im = bf.a1_im + bf.a3_im;
    assign d13_re = bf.a1_re - bf.a3_re;
    assign d13_im = bf.a1_im - bf.a3_im;

    assign bf.y0_re = s02_re + s13_re;
    assign bf.y0_im = s02_im + s13_im;

    // y1 = d02 - j*d13, multiply by -j swaps parts
    assign bf.y1_re = d02_re + d13_im;
    assign bf.y1_im = d02_im - d13_re;

    assign bf.y2_re = s02_re - s13_re;
    assign bf.y2_im = s02_im - s13_im;

    // y3 = d02 + j*d13
    assign bf.y3_re = d02_re - d13_im;
    assign bf.y3_im = d02_im + d13_re;

endmodule

`default_nettype wire

/* hdl/sdf_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module sdf_stage #(
    parameter int width = 15,
    parameter int depth = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  fft_types_pkg::stage_phase_t phase,
    input  logic signed [width-1:0]     din_re,
    input  logic signed [width-1:0]     din_im,
    output logic signed [width-1:0]     dout_re,
    output logic signed [width-1:0]     dout_im
);
    // Three feedback lines with entry 0 the newest
    logic signed [width-1:0] line_re [3][depth];
    logic signed [width-1:0] line_im [3][depth];
    logic signed [width-1:0] line_in_re [3];
    logic signed [width-1:0] line_in_im [3];
    logic [2:0] fill_en;
    logic [2:0] line_en;
    logic computing;

    radix4_if #(.width(width)) bf_bus ();

    radix4_butterfly #(.width(width)) butterfly_i (
        .bf(bf_bus.butterfly)
    );

    assign computing = (phase == fft_types_pkg::compute);
    assign fill_en[0] = (phase == fft_types_pkg::fill_0);
    assign fill_en[1] = (phase == fft_types_pkg::fill_1);
    assign fill_en[2] = (phase == fft_types_pkg::fill_2);

    // Every line shifts during compute
    assign line_en = fill_en | {3{computing}};

    // Fresh samples while filling, butterfly results while computing
    always_comb
    begin
        line_in_re[0] = computing ? bf_bus.y1_re : din_re;
        line_in_im[0] = computing ? bf_bus.y1_im : din_im;
        line_in_re[1] = computing ? bf_bus.y2_re : din_re;
        line_in_im[1] = computing ? bf_bus.y2_im : din_im;
        line_in_re[2] = computing ? bf_bus.y3_re : din_re;
        line_in_im[2] = computing ? bf_bus.y3_im : din_im;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int l = 0; l < 3; l++)
            begin
                for (int i = 0; i < depth; i++)
                begin
                    line_re[l][i] <= '0;
                    line_im[l][i] <= '0;
                end
            end
        end
        else
        begin
            for (int l = 0; l < 3; l++)
            begin
                if (line_en[l])
                begin
                    line_re[l][0] <= line_in_re[l];
                    line_im[l][0] <= line_in_im[l];
                    for (int i = 1; i < depth; i++)
                    begin
                        line_re[l][i] <= line_re[l][i-1];
                        line_im[l][i] <= line_im[l][i-1];
                    end
                end
            end
        end
    end

    // Upper input walks the line outputs, so y0 drains results in fill phases
    always_comb
    begin
        case (phase)
            fft_types_pkg::fill_1:
            begin
                bf_bus.a0_re = line_re[1][depth-1];
                bf_bus.a0_im = line_im[1][depth-1];
            end
            fft_types_pkg::fill_2:
            begin
                bf_bus.a0_re = line_re[2][depth-1];
                bf_bus.a0_im = line_im[2][depth-1];
            end
            default:
            begin
                bf_bus.a0_re = line_re[0][depth-1];
                bf_bus.a0_im = line_im[0][depth-1];
            end
        endcase
    end

    // Lower inputs only take part in compute
    assign bf_bus.a1_re = computing ? line_re[1][depth-1] : '0;
    assign bf_bus.a1_im = computing ? line_im[1][depth-1] : '0;
    assign bf_bus.a2_re = computing ? line_re[2][depth-1] : '0;
    assign bf_bus.a2_im = computing ? line_im[2][depth-1] : '0;
    assign bf_bus.a3_re = computing ? din_re : '0;
    assign bf_bus.a3_im = computing ? din_im : '0;

    assign dout_re = bf_bus.y0_re;
    assign dout_im = bf_bus.y0_im;

    // Lines fill one after another, so the phase only ever steps forward by one
    assert property (@(posedge clk) disable iff (reset)
        (phase != $past(phase)) |-> (2'(phase) == 2'($past(phase)) + 2'd1));

endmodule

`default_nettype wire

/* hdl/twiddle_rotator.sv */
`timescale 1ns/1ns
`default_nettype none

module twiddle_rotator #(
    parameter int in_width = 15,
    parameter int out_width = 17,
    parameter int depth = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  fft_types_pkg::frame_count_t count,
    input  logic signed [in_width-1:0]  din_re,
    input  logic signed [in_width-1:0]  din_im,
    output logic signed [out_width-1:0] dout_re,
    output logic signed [out_width-1:0] dout_im
);
    localparam int prod_width = in_width + twiddle_pkg::twiddle_width + 1;
    localparam int cb = fft_types_pkg::counter_bits;

    fft_types_pkg::stage_phase_t quarter;
    logic [1:0] tw_group;
    fft_types_pkg::frame_count_t tw_index;
    twiddle_pkg::twiddle_t w_re;
    twiddle_pkg::twiddle_t w_im;
    logic signed [prod_width-1:0] prod_re;
    logic signed [prod_width-1:0] prod_im;
    logic signed [in_width-1:0] rot_re;
    logic signed [in_width-1:0] rot_im;
    logic signed [out_width-1:0] dly_re [depth];
    logic signed [out_width-1:0] dly_im [depth];

    // Stage 1 emits y0 in compute, y1 to y3 in the following fill quarters
    assign quarter = fft_types_pkg::stage_phase_t'(count[cb-1 -: 2]);
    assign tw_group = (quarter == fft_types_pkg::compute) ? 2'd0 : 2'(quarter) + 2'd1;
    assign tw_index = {tw_group, count[1:0]};

    assign w_re = twiddle_pkg::twiddle_re[tw_index];
    assign w_im = twiddle_pkg::twiddle_im[tw_index];

    assign prod_re = din_re * w_re - din_im * w_im;
    assign prod_im = din_re * w_im + din_im * w_re;

    // Drop the fraction bits, rounding toward minus infinity
    assign rot_re = prod_re[twiddle_pkg::twiddle_frac_bits +: in_width];
    assign rot_im = prod_im[twiddle_pkg::twiddle_frac_bits +: in_width];

    // Realigns each group of four onto the next stage's quarter boundaries
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < depth; i++)
            begin
                dly_re[i] <= '0;
                dly_im[i] <= '0;
            end
        end
        else
        begin
            dly_re[0] <= {{(out_width-in_width){rot_re[in_width-1]}}, rot_re};
            dly_im[0] <= {{(out_width-in_width){rot_im[in_width-1]}}, rot_im};
            for (int i = 1; i < depth; i++)
            begin
                dly_re[i] <= dly_re[i-1];
                dly_im[i] <= dly_im[i-1];
            end
        end
    end

    assign dout_re = dly_re[depth-1];
    assign dout_im = dly_im[depth-1];

    // Count 0 takes twiddle 1, so the product equals the input
    assert property (@(posedge clk) disable iff (reset)
        (count == '0) |=> (dly_re[0] == $past(din_re) && dly_im[0] == $past(din_im)));

endmodule

`default_nettype wire

/* hdl/fft16_sdf.sv */
`timescale 1ns/1ns
`default_nettype none

module fft16_sdf (
    input  logic                      clk,
    input  logic                      reset,
    input  fft_types_pkg::in_sample_t x_re,
    input  fft_types_pkg::in_sample_t x_im,
    output fft_types_pkg::s2_sample_t y_re,
    output fft_types_pkg::s2_sample_t y_im
);
    localparam int stage1_depth = fft_types_pkg::fft_points / fft_types_pkg::radix;
    localparam int stage2_depth = stage1_depth / fft_types_pkg::radix;
    localparam int in_width = fft_types_pkg::in_width;
    localparam int s1_width = fft_types_pkg::s1_width;
    localparam int cb = fft_types_pkg::counter_bits;

    fft_types_pkg::frame_count_t count;
    fft_types_pkg::s1_sample_t x_reg_re;
    fft_types_pkg::s1_sample_t x_reg_im;
    fft_types_pkg::s1_sample_t s1_re;
    fft_types_pkg::s1_sample_t s1_im;
    fft_types_pkg::s2_sample_t rot_re;
    fft_types_pkg::s2_sample_t rot_im;
    fft_types_pkg::stage_phase_t s1_phase;
    fft_types_pkg::stage_phase_t s2_phase;

    // Starts at all ones so the first edge after reset lands on sample 0
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            count <= '1;
        else
            count <= count + fft_types_pkg::frame_count_t'(1);
    end

    // Sign extend the input by two bits of headroom
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            x_reg_re <= '0;
            x_reg_im <= '0;
        end
        else
        begin
            x_reg_re <= {{(s1_width-in_width){x_re[in_width-1]}}, x_re};
            x_reg_im <= {{(s1_width-in_width){x_im[in_width-1]}}, x_im};
        end
    end

    assign s1_phase = fft_types_pkg::stage_phase_t'(count[cb-1 -: 2]);
    assign s2_phase = fft_types_pkg::stage_phase_t'(count[1:0]);

    sdf_stage #(
        .width(s1_width),
        .depth(stage1_depth)
    ) stage1_i (
        .clk(clk),
        .reset(reset),
        .phase(s1_phase),
        .din_re(x_reg_re),
        .din_im(x_reg_im),
        .dout_re(s1_re),
        .dout_im(s1_im)
    );

    twiddle_rotator #(
        .in_width(s1_width),
        .out_width(fft_types_pkg::s2_width),
        .depth(stage1_depth)
    ) rotator_i (
        .clk(clk),
        .reset(reset),
        .count(count),
        .din_re(s1_re),
        .din_im(s1_im),
        .dout_re(rot_re),
        .dout_im(rot_im)
    );

    // Output bins leave in digit-reversed order
    sdf_stage #(
        .width(fft_types_pkg::s2_width),
        .depth(stage2_depth)
    ) stage2_i (
        .clk(clk),
        .reset(reset),
        .phase(s2_phase),
        .din_re(rot_re),
        .din_im(rot_im),
        .dout_re(y_re),
        .dout_im(y_im)
    );

    // Counter width has to match the frame length for the wrap to land on 0
    assert property (@(posedge clk) disable iff (reset)
        (count == fft_types_pkg::frame_count_t'(fft_types_pkg::fft_points - 1)) |=> (count == '0));

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int period = 10
) (
    output logic clk
);
    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* tests/tb_fft16_sdf.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fft16_sdf;

    localparam int reset_cycles = 2;
    localparam int latency = 19;
    localparam int points = fft_types_pkg::fft_points;
    localparam int tolerance = 8;
    // Frames compared against the model over all runs
    localparam int checked_frames = 214;
    // The aborted stream before the mid-run reset is under three frames long
    localparam int aborted_frames = 3;
    localparam int num_runs = 6;
    localparam int timeout_cycles =
        2 * (num_runs * (reset_cycles + latency) + (checked_frames + aborted_frames) * points);
    localparam real two_pi = 6.283185307179586;

    logic clk;
    logic reset;
    fft_types_pkg::in_sample_t x_re;
    fft_types_pkg::in_sample_t x_im;
    fft_types_pkg::s2_sample_t y_re;
    fft_types_pkg::s2_sample_t y_im;

    // Samples of the frames waiting to be streamed
    int stim_re [$];
    int stim_im [$];
    int bins_checked;
    int cycle_count = 0;

    tb_clock #(.period(10)) clock_i (.clk(clk));

    fft16_sdf fft16_sdf_i (
        .clk(clk),
        .reset(reset),
        .x_re(x_re),
        .x_im(x_im),
        .y_re(y_re),
        .y_im(y_im)
    );

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles)
        begin
            $display("Timeout: the run did not end within %0d clock cycles", timeout_cycles);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    function automatic int rand_component();
        return int'($urandom % 4095) - 2047;
    endfunction

    // Floating-point DFT of one queued frame
    function automatic real dft_bin(input int frame, input int bin, input bit imag);
        real acc;
        real theta;
        int idx;
        acc = 0.0;
        for (int n = 0; n < points; n++)
        begin
            idx = frame * points + n;
            theta = two_pi * real'(n * bin) / real'(points);
            if (imag)
                acc = acc + real'(stim_im[idx]) * $cos(theta) - real'(stim_re[idx]) * $sin(theta);
            else
                acc = acc + real'(stim_re[idx]) * $cos(theta) + real'(stim_im[idx]) * $sin(theta);
        end
        return acc;
    endfunction

    task automatic compare_close(input string name, input int actual, input real expected);
        real diff;
        diff = real'(actual) - expected;
        if (diff > tolerance || diff < -tolerance)
        begin
            $display("ERR %0t %s: got %0d, expected %0.2f", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic drive_sample(input int re, input int im);
        x_re = fft_types_pkg::in_sample_t'(re);
        x_im = fft_types_pkg::in_sample_t'(im);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        drive_sample(0, 0);
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic push_sample(input int re, input int im);
        stim_re.push_back(re);
        stim_im.push_back(im);
    endtask

    task automatic add_impulse(input int re, input int im);
        push_sample(re, im);
        for (int n = 1; n < points; n++)
            push_sample(0, 0);
    endtask

    task automatic add_constant(input int re, input int im);
        for (int n = 0; n < points; n++)
            push_sample(re, im);
    endtask

    // Complex exponential landing in bin k
    task automatic add_tone(input int k, input int amp);
        real theta;
        for (int n = 0; n < points; n++)
        begin
            theta = two_pi * real'(k * n) / real'(points);
            push_sample(int'(amp * $cos(theta)), int'(amp * $sin(theta)));
        end
    endtask

    task automatic add_random_frame();
        for (int n = 0; n < points; n++)
            push_sample(rand_component(), rand_component());
    endtask

    // Reset, stream every queued frame, then compare each output bin with the model
    task automatic stream_and_check();
        int frames;
        int total;
        int f;
        int m;
        int bin;
        frames = stim_re.size() / points;
        total = frames * points + latency;
        apply_reset();
        for (int t = 0; t < total; t++)
        begin
            if (t < frames * points)
                drive_sample(stim_re[t], stim_im[t]);
            else
                drive_sample(0, 0);
            @(posedge clk);
            #1;
            if (t >= latency)
            begin
                f = (t - latency) / points;
                m = (t - latency) % points;
                // Bins leave in digit-reversed order
                bin = 4 * (m % 4) + m / 4;
                compare_close($sformatf("y_re bin %0d", bin), int'(y_re), dft_bin(f, bin, 1'b0));
                compare_close($sformatf("y_im bin %0d", bin), int'(y_im), dft_bin(f, bin, 1'b1));
                bins_checked++;
            end
        end
        stim_re.delete();
        stim_im.delete();
    endtask

    initial
    begin
        void'($urandom(32'h2f3f65b7));
        reset = 1'b1;
        x_re = '0;
        x_im = '0;
        bins_checked = 0;

        add_constant(0, 0);
        add_constant(0, 0);
        stream_and_check();

        // Flat spectrum from a single impulse
        add_impulse(rand_component(), rand_component());
        stream_and_check();

        add_constant(rand_component(), rand_component());
        add_constant(rand_component(), rand_component());
        stream_and_check();

        // Tones at random bins go through every twiddle row
        for (int i = 0; i < 6; i++)
            add_tone(int'($urandom % 16), 1024);
        stream_and_check();

        for (int i = 0; i < 200; i++)
            add_random_frame();
        stream_and_check();

        // Abort a stream partway through a frame, then realign after reset
        for (int i = 0; i < 37; i++)
        begin
            drive_sample(rand_component(), rand_component());
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < 3; i++)
            add_random_frame();
        stream_and_check();

        if (bins_checked == checked_frames * points)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
        begin
            $display("Only %0d of %0d bins were compared", bins_checked, checked_frames * points);
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/fft_types_pkg.sv
hdl/twiddle_pkg.sv
hdl/radix4_if.sv
hdl/radix4_butterfly.sv
hdl/sdf_stage.sv
hdl/twiddle_rotator.sv
hdl/fft16_sdf.sv
tests/tb_clock.sv
tests/tb_fft16_sdf.sv

/* Makefile */
TOP = tb_fft16_sdf

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f compile.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
